/* sources.f */
+incdir+rtl
rtl/ls_op_pkg.sv
rtl/ls_mem_pkg.sv
rtl/ls_sub_if.sv
rtl/ls_fifo.sv
rtl/ls_issue.sv
rtl/ls_scratch_ram.sv
rtl/ls_load_align.sv
rtl/load_store_unit.sv
sim/ls_props.sv
sim/tb_load_store_unit.sv

/* sim/tb_load_store_unit.sv */
// Testbench for the load/store unit.
// Keeps a byte model of the scratch memory, predicts every load result and
// exception address in request order, and compares them as the DUT delivers.
// Covers word fill and readback, sub-word accesses with sign extension,
// misaligned accesses, negative offsets and writeback back-pressure.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module tb_load_store_unit;

    import ls_op_pkg::*;

    localparam int mem_bytes      = `LS_RAM_WORDS * 4;
    localparam int timeout_cycles = 500;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic        req_load;
    logic        req_store;
    ls_fn3_t     req_fn3;
    logic [31:0] req_base;
    logic [11:0] req_offset;
    logic [31:0] req_wdata;
    logic        wb_valid;
    logic [31:0] wb_data;
    logic        wb_accept;
    logic        exc_valid;
    logic [31:0] exc_addr;

    int          seed = 1125;
    logic [7:0]  model_mem [mem_bytes];
    logic [31:0] exp_results [$];
    logic [31:0] exp_exc [$];
    logic        stall_mode;
    logic        saw_not_ready;

    load_store_unit UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_load   (req_load),
        .req_store  (req_store),
        .req_fn3    (req_fn3),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_accept  (wb_accept),
        .exc_valid  (exc_valid),
        .exc_addr   (exc_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    // Expected load result from the model, little-endian lanes
    function automatic logic [31:0] expected_load(input logic [31:0] addr, input ls_fn3_t fn3);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr % mem_bytes;
        b = model_mem[a];
        h = {model_mem[a + 1], model_mem[a]};
        case (fn3)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return {model_mem[a + 3], model_mem[a + 2], h};
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input ls_fn3_t fn3,
                               input logic [31:0] wdata);
        int a;
        int n;
        a = addr % mem_bytes;
        n = (fn3 == LB) ? 1 : (fn3 == LH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model_mem[a + i] = wdata[i*8 +: 8];
        end
    endtask

    // Predict the outcome, then hold the request until it is taken
    task automatic issue_access(input logic load, input ls_fn3_t fn3, input logic [31:0] addr,
                                input logic [11:0] offset, input logic [31:0] wdata);
        logic misaligned;
        int   waited;
        if (fn3 == LH || fn3 == LHU) begin
            misaligned = addr[0];
        end else if (fn3 == LW) begin
            misaligned = (addr[1:0] != 2'b00);
        end else begin
            misaligned = 1'b0;
        end
        if (misaligned) begin
            exp_exc.push_back(addr);
        end else if (!load) begin
            model_store(addr, fn3, wdata);
        end else begin
            exp_results.push_back(expected_load(addr, fn3));
        end
        req_valid  = 1'b1;
        req_load   = load;
        req_store  = !load;
        req_fn3    = fn3;
        req_base   = addr - {{20{offset[11]}}, offset};
        req_offset = offset;
        req_wdata  = wdata;
        waited = 0;
        while (!req_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("Timed out waiting for req_ready");
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic random_access();
        int          r;
        ls_fn3_t     fn3;
        logic [31:0] addr;
        logic [11:0] offset;
        r = $random(seed) & 7;
        case (r)
            0, 2:    fn3 = LB;
            1, 4:    fn3 = LH;
            3:       fn3 = LBU;
            5:       fn3 = LHU;
            default: fn3 = LW;
        endcase
        addr   = $random(seed);
        offset = $random(seed);
        if (fn3 == LH || fn3 == LHU) begin
            addr[0] = 1'b0;
        end else if (fn3 == LW) begin
            addr[1:0] = 2'b00;
        end
        // Codes 0, 1 and 7 are SB, SH and SW
        issue_access(!(r == 0 || r == 1 || r == 7), fn3, addr, offset, $random(seed));
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_results.size() != 0 || exp_exc.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("Timed out waiting for outstanding results and exceptions");
            end
        end
    endtask

    // Accept held low for 40 of every 46 cycles while stalling
    initial begin
        int phase;
        wb_accept = 1'b1;
        phase = 0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_mode) begin
                phase = (phase + 1) % 46;
                wb_accept = (phase >= 40);
            end else begin
                phase = 0;
                wb_accept = 1'b1;
            end
        end
    end

    // Compare writebacks and exceptions against the expected queues
    always @(posedge clk) begin
        if (!rst) begin
            if (wb_valid && wb_accept) begin
                if (exp_results.size() == 0) begin
                    abort_run("Writeback arrived with no load outstanding");
                end else begin
                    check_value("wb_data", wb_data, exp_results.pop_front());
                end
            end
            if (exc_valid) begin
                if (exp_exc.size() == 0) begin
                    abort_run("Exception pulse with no misaligned request outstanding");
                end else begin
                    check_value("exc_addr", exc_addr, exp_exc.pop_front());
                end
            end
            if (stall_mode && !req_ready) begin
                saw_not_ready = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] addr;
        logic [11:0] offset;
        ls_fn3_t     fn3;
        rst           = 1'b1;
        req_valid     = 1'b0;
        req_load      = 1'b0;
        req_store     = 1'b0;
        req_fn3       = LB;
        req_base      = '0;
        req_offset    = '0;
        req_wdata     = '0;
        stall_mode    = 1'b0;
        saw_not_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("req_ready", req_ready, 1'b1);
        check_value("wb_valid", wb_valid, 1'b0);
        check_value("exc_valid", exc_valid, 1'b0);
        check_value("new_request", UUT.sub.new_request, 1'b0);

        // Fill every word, then read a random selection back
        for (int w = 0; w < `LS_RAM_WORDS; w++) begin
            issue_access(1'b0, LW, w * 4, 12'd0, $random(seed));
        end
        for (int i = 0; i < 64; i++) begin
            addr = $random(seed);
            addr[1:0] = 2'b00;
            issue_access(1'b1, LW, addr, $random(seed), 32'd0);
        end

        for (int i = 0; i < 300; i++) begin
            random_access();
        end

        // Misaligned accesses, then a word load over the same spot
        for (int i = 0; i < 16; i++) begin
            addr = $random(seed);
            fn3 = (i % 2 == 0) ? LH : LW;
            if (fn3 == LH) begin
                addr[1:0] = (i % 4 == 0) ? 2'b01 : 2'b11;
            end else begin
                addr[1:0] = 2'(i % 3 + 1);
            end
            issue_access(i < 8, fn3, addr, $random(seed), $random(seed));
            issue_access(1'b1, LW, {addr[31:2], 2'b00}, 12'd0, 32'd0);
        end

        // Negative offsets only
        for (int i = 0; i < 16; i++) begin
            addr = $random(seed);
            addr[1:0] = 2'b00;
            offset = $random(seed) | 12'h800;
            issue_access(1'b1, LW, addr, offset, 32'd0);
        end

        stall_mode = 1'b1;
        for (int i = 0; i < 120; i++) begin
            random_access();
        end
        stall_mode = 1'b0;

        wait_drain();
        check_value("saw_req_ready_low", saw_not_ready, 1'b1);
        check_value("assertion_errors",
                    UUT.input_fifo.fifo_props.errors + UUT.align.attr_fifo.fifo_props.errors +
                    UUT.align.result_fifo.fifo_props.errors + UUT.issue.issue_props.errors,
                    32'd0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/ls_props.sv */
// Concurrent properties for the load/store unit.
// Bound into every queue and into the issue stage, sized per binding.
// Inputs that a binding has no use for are tied low, so those properties
// hold trivially there.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module ls_props #(
    parameter int head_w = 1,
    parameter int cnt_w  = 1
) (
    input logic              clk,
    input logic              rst,
    input logic              push,
    input logic              pop,
    input logic              valid,
    input logic              full,
    input logic [head_w-1:0] head,
    input logic [cnt_w-1:0]  inflight
);

    int errors = 0;

    // Queue overflow and underflow
    assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else begin
            $error("push into a full queue");
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) !valid |-> !pop)
        else begin
            $error("pop from an empty queue");
            errors = errors + 1;
        end

    // Head entry holds while it waits to leave, this covers wb_data
    assert property (@(posedge clk) disable iff (rst) valid && !pop |=> $stable(head))
        else begin
            $error("queue head changed before it was taken");
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) inflight <= `LS_INFLIGHT_MAX)
        else begin
            $error("too many loads in flight");
            errors = errors + 1;
        end

endmodule

bind ls_fifo ls_props #(
    .head_w ($bits(data_out)),
    .cnt_w  (1)
) fifo_props (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pop      (pop),
    .valid    (valid),
    .full     (full),
    .head     (data_out),
    .inflight (1'b0)
);

bind ls_issue ls_props #(
    .head_w (1),
    .cnt_w  ($bits(inflight))
) issue_props (
    .clk      (clk),
    .rst      (rst),
    .push     (1'b0),
    .pop      (1'b0),
    .valid    (1'b0),
    .full     (1'b0),
    .head     (1'b0),
    .inflight (inflight)
);

`default_nettype wire

/* rtl/load_store_unit.sv */
// Top level of the load/store unit.
// Requests arrive on a valid/ready handshake, results leave on a
// valid/accept handshake in request order, and misaligned accesses
// report a one-cycle exception pulse with the faulting address.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module load_store_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  logic               req_load,
    input  logic               req_store,
    input  ls_op_pkg::ls_fn3_t req_fn3,
    input  logic [31:0]        req_base,
    input  logic [11:0]        req_offset,
    input  logic [31:0]        req_wdata,
    output logic               wb_valid,
    output logic [31:0]        wb_data,
    input  logic               wb_accept,
    output logic               exc_valid,
    output logic [31:0]        exc_addr
);

    import ls_op_pkg::*;
    import ls_mem_pkg::*;

    ls_request_t   req_in;
    ls_request_t   req_head;
    logic          req_head_valid;
    logic          req_full;
    logic          req_pop;
    logic          attr_push;
    ls_load_attr_t attr;
    logic          wb_transfer;

    ls_sub_if sub ();

    assign req_in.load   = req_load;
    assign req_in.store  = req_store;
    assign req_in.fn3    = req_fn3;
    assign req_in.base   = req_base;
    assign req_in.offset = req_offset;
    assign req_in.wdata  = req_wdata;

    assign req_ready   = !req_full;
    assign wb_transfer = wb_valid && wb_accept;

    ls_fifo #(
        .payload_t (ls_request_t),
        .DEPTH     (`LS_INPUT_DEPTH)
    ) input_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (req_valid && req_ready),
        .data_in  (req_in),
        .pop      (req_pop),
        .data_out (req_head),
        .valid    (req_head_valid),
        .full     (req_full)
    );

    // In-flight count drops only on a completed writeback
    ls_issue issue (
        .clk       (clk),
        .rst       (rst),
        .req       (req_head),
        .req_valid (req_head_valid),
        .req_pop   (req_pop),
        .mem       (sub.requester),
        .attr_push (attr_push),
        .attr      (attr),
        .wb_accept (wb_transfer),
        .exc_valid (exc_valid),
        .exc_addr  (exc_addr)
    );

    ls_scratch_ram scratch (
        .clk (clk),
        .rst (rst),
        .mem (sub.unit)
    );

    ls_load_align align (
        .clk        (clk),
        .rst        (rst),
        .attr_push  (attr_push),
        .attr       (attr),
        .rdata      (sub.rdata),
        .data_valid (sub.data_valid),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_accept  (wb_accept)
    );

endmodule

`default_nettype wire

/* rtl/ls_load_align.sv */
// Load alignment and writeback stage.
// Keeps the attributes of loads in flight, and when memory data returns
// picks the addressed byte or halfword, extends it and queues the result.
// The result queue drives the valid/accept writeback handshake.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module ls_load_align (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      attr_push,
    input  ls_mem_pkg::ls_load_attr_t attr,
    input  logic [31:0]               rdata,
    input  logic                      data_valid,
    output logic                      wb_valid,
    output logic [31:0]               wb_data,
    input  logic                      wb_accept
);

    import ls_op_pkg::*;
    import ls_mem_pkg::*;

    ls_load_attr_t       attr_head;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;
    logic [`LS_XLEN-1:0] result;

    // Attributes of issued loads, oldest at the head
    ls_fifo #(
        .payload_t (ls_load_attr_t),
        .DEPTH     (`LS_INFLIGHT_MAX)
    ) attr_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (attr_push),
        .data_in  (attr),
        .pop      (data_valid),
        .data_out (attr_head),
        .valid    (),
        .full     ()
    );

    assign byte_sel = rdata[attr_head.byte_offset*8 +: 8];
    assign half_sel = attr_head.byte_offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (attr_head.fn3)
            LB:      result = {{24{byte_sel[7]}}, byte_sel};
            LH:      result = {{16{half_sel[15]}}, half_sel};
            LBU:     result = {24'b0, byte_sel};
            LHU:     result = {16'b0, half_sel};
            default: result = rdata;
        endcase
    end

    ls_fifo #(
        .payload_t (logic [`LS_XLEN-1:0]),
        .DEPTH     (`LS_INFLIGHT_MAX)
    ) result_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (data_valid),
        .data_in  (result),
        .pop      (wb_valid && wb_accept),
        .data_out (wb_data),
        .valid    (wb_valid),
        .full     ()
    );

endmodule

`default_nettype wire

/* rtl/ls_scratch_ram.sv */
// Local scratch data memory for the load/store unit.
// Single port, writes by byte lane at the request edge, reads return the
// full word one cycle after the request together with data_valid.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module ls_scratch_ram (
    input  logic   clk,
    input  logic   rst,
    ls_sub_if.unit mem
);

    localparam int idx_w = $clog2(`LS_RAM_WORDS);

    logic [`LS_XLEN-1:0] ram [`LS_RAM_WORDS];
    logic [idx_w-1:0]    idx;
    logic                rd_valid;
    logic [`LS_XLEN-1:0] rd_word;

    // Upper address bits are ignored so accesses wrap
    assign idx = mem.mem_req.word_addr[idx_w-1:0];

    always_ff @(posedge clk) begin
        if (mem.new_request && mem.mem_req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (mem.mem_req.be[i]) begin
                    ram[idx][i*8 +: 8] <= mem.mem_req.wdata[i*8 +: 8];
                end
            end
        end
        if (mem.new_request && !mem.mem_req.write) begin
            rd_word <= ram[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem.new_request && !mem.mem_req.write;
        end
    end

    // Never stalls
    assign mem.ready      = 1'b1;
    assign mem.rdata      = rd_word;
    assign mem.data_valid = rd_valid;

endmodule

`default_nettype wire

/* rtl/ls_issue.sv */
// Issue stage of the load/store unit.
// Takes the head of the request queue, forms the effective address, checks
// alignment, builds byte enables and replicated store data, and starts the
// memory access. Loads also push their attributes toward the align stage.
// Misaligned requests are dropped with an exception pulse.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

module ls_issue (
    input  logic                      clk,
    input  logic                      rst,
    input  ls_op_pkg::ls_request_t    req,
    input  logic                      req_valid,
    output logic                      req_pop,
    ls_sub_if.requester               mem,
    output logic                      attr_push,
    output ls_mem_pkg::ls_load_attr_t attr,
    input  logic                      wb_accept,
    output logic                      exc_valid,
    output logic [31:0]               exc_addr
);

    import ls_op_pkg::*;
    import ls_mem_pkg::*;

    localparam int inflight_w = $clog2(`LS_INFLIGHT_MAX + 1);

    logic [`LS_XLEN-1:0]  addr;
    logic                 misaligned;
    logic                 access;
    logic                 is_load;
    logic                 load_room;
    logic                 issue;
    logic [3:0]           be;
    logic [`LS_XLEN-1:0]  wdata_rep;
    logic [inflight_w-1:0] inflight;
    ls_mem_req_t          mem_req;

    assign addr = req.base + {{(`LS_XLEN - 12){req.offset[11]}}, req.offset};

    // Halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (req.fn3[1:0])
            2'b01:   misaligned = addr[0];
            2'b10:   misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Lane enables only for stores
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (req.fn3[1:0])
                2'b00:   be[i] = req.store && (addr[1:0] == 2'(i));
                2'b01:   be[i] = req.store && (addr[1] == 1'(i >> 1));
                2'b10:   be[i] = req.store;
                default: be[i] = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (req.fn3[1:0])
            2'b00:   wdata_rep = {4{req.wdata[7:0]}};
            2'b01:   wdata_rep = {2{req.wdata[15:0]}};
            default: wdata_rep = req.wdata;
        endcase
    end

    assign access    = req.load || req.store;
    assign is_load   = req.load && !req.store;
    assign load_room = (inflight < inflight_w'(`LS_INFLIGHT_MAX));

    // Loads wait for room in flight, stores go straight through
    assign issue = req_valid && access && !misaligned && mem.ready &&
                   (!is_load || load_room);

    assign exc_valid = req_valid && access && misaligned;
    assign exc_addr  = addr;

    // Requests with no operation are simply discarded
    assign req_pop = issue || exc_valid || (req_valid && !access);

    assign mem_req.word_addr = addr[`LS_XLEN-1:2];
    assign mem_req.be        = be;
    assign mem_req.wdata     = wdata_rep;
    assign mem_req.write     = req.store;

    assign mem.new_request = issue;
    assign mem.mem_req     = mem_req;

    assign attr_push        = issue && is_load;
    assign attr.fn3         = req.fn3;
    assign attr.byte_offset = addr[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
        end else if (attr_push && !wb_accept) begin
            inflight <= inflight + 1'b1;
        end else if (wb_accept && !attr_push) begin
            inflight <= inflight - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/ls_fifo.sv */
// Synchronous queue with a selectable payload type.
// The head entry is shown on data_out while valid is high and leaves on pop.
// Pushing while full or popping while empty is not allowed.

`timescale 1ns/1ps
`default_nettype none

module ls_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);

    localparam int ptr_w   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int count_w = $clog2(DEPTH + 1);

    payload_t             entries [DEPTH];
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w-1:0]     wr_ptr;
    logic [count_w-1:0]   count;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == count_w'(DEPTH));

endmodule

`default_nettype wire

/* rtl/ls_sub_if.sv */
// Connection between the issue stage and a memory sub-unit.
// The issue stage takes the requester side, the memory the unit side.
// An access is taken in any cycle with new_request and ready both high.

`timescale 1ns/1ps
`default_nettype none

`include "ls_consts.svh"

interface ls_sub_if;

    import ls_mem_pkg::*;

    logic                new_request;
    ls_mem_req_t         mem_req;
    logic                ready;
    logic [`LS_XLEN-1:0] rdata;
    logic                data_valid;

    modport requester (
        output new_request,
        output mem_req,
        input  ready,
        input  rdata,
        input  data_valid
    );

    modport unit (
        input  new_request,
        input  mem_req,
        output ready,
        output rdata,
        output data_valid
    );

endinterface

`default_nettype wire

/* rtl/ls_mem_pkg.sv */
// Memory-side types of the load/store unit.
// The access record sent to the scratch memory and the attributes a load
// carries until its data returns.

`default_nettype none

package ls_mem_pkg;

`include "ls_consts.svh"

    import ls_op_pkg::*;

    typedef struct packed {
        logic [`LS_XLEN-3:0] word_addr;
        logic [3:0]          be;
        logic [`LS_XLEN-1:0] wdata;
        logic                write;
    } ls_mem_req_t;

    // What the align stage needs to shape the returned word
    typedef struct packed {
        ls_fn3_t    fn3;
        logic [1:0] byte_offset;
    } ls_load_attr_t;

endpackage

`default_nettype wire

/* rtl/ls_op_pkg.sv */
// Operation types of the load/store unit.
// Holds the function code encoding and the request record that travels
// from the top level ports through the request queue into the issue stage.

`default_nettype none

package ls_op_pkg;

`include "ls_consts.svh"

    // Function codes, stores reuse the LB, LH and LW encodings
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } ls_fn3_t;

    // One load or store as accepted from the core
    typedef struct packed {
        logic                load;
        logic                store;
        ls_fn3_t             fn3;
        logic [`LS_XLEN-1:0] base;
        logic signed [11:0]  offset;
        logic [`LS_XLEN-1:0] wdata;
    } ls_request_t;

endpackage

`default_nettype wire

/* rtl/ls_consts.svh */
// Sizing constants for the load/store unit.
// Included by every RTL file that needs a width, a memory size or a queue depth.

`ifndef LS_CONSTS_SVH
`define LS_CONSTS_SVH

// Data and address width
`define LS_XLEN 32

// Scratch memory size in 32-bit words, addresses wrap around it
`define LS_RAM_WORDS 256

// Request queue depth
`define LS_INPUT_DEPTH 4

// Loads issued but not yet accepted at writeback
// Also the depth of the attribute and result queues
`define LS_INFLIGHT_MAX 2

`endif
